//--- boot_rom.hex
// One 32-bit boot word per line, word 0 at ROM_BASE.
020000b7
00500113
0020a023
030001b7
0a500213
00d21213
05020213
0041a023
0041a283
0012f293
fe029ce3
0022f293
00000313
00628463
00100313
0000006f

//--- flist.f
soc_pkg.sv
soc_bus_ctrl.sv
soc_ram.sv
soc_boot_rom.sv
soc_led.sv
soc_i2c.sv
soc_periph.sv
tb_i2c_target.sv
tb_soc_periph.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_soc_periph -o tb_soc_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_periph > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

//--- soc_boot_rom.sv
`timescale 1ns/1ns

module soc_boot_rom (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  soc_pkg::addr_t addr,
    input  soc_pkg::strb_t wstrb,
    output logic           ready,
    output soc_pkg::data_t rdata
);

    import soc_pkg::*;

    localparam int IDX_W = $clog2(ROM_WORDS);

    data_t            mem [ROM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             accept;

    initial $readmemh("boot_rom.hex", mem);

    assign word_idx = addr[IDX_W+1:2];
    assign accept   = sel & ~ready;

    // Writes are acknowledged but never reach the array.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
            rdata <= '0;
        end else begin
            ready <= accept;
            rdata <= (accept && wstrb == '0) ? mem[word_idx] : '0;
        end
    end

endmodule

//--- soc_bus_ctrl.sv
`timescale 1ns/1ns

module soc_bus_ctrl #(
    parameter int RAM_WORDS = 1024
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           mem_valid,
    input  soc_pkg::addr_t mem_addr,
    input  logic           ram_ready,
    input  logic           rom_ready,
    input  logic           led_ready,
    input  logic           i2c_ready,
    input  soc_pkg::data_t ram_rdata,
    input  soc_pkg::data_t rom_rdata,
    input  soc_pkg::data_t led_rdata,
    input  soc_pkg::data_t i2c_rdata,
    output logic           ram_sel,
    output logic           rom_sel,
    output logic           led_sel,
    output logic           i2c_sel,
    output logic           mem_ready,
    output soc_pkg::data_t mem_rdata
);

    import soc_pkg::*;

    logic [31-REGION_SHIFT:0] region;
    logic [REGION_SHIFT-3:0]  word_ofs;
    logic                     ram_hit;
    logic                     rom_hit;
    logic                     led_hit;
    logic                     i2c_hit;
    logic                     dflt_sel;
    logic                     dflt_ready;

    assign region   = mem_addr[31:REGION_SHIFT];
    assign word_ofs = mem_addr[REGION_SHIFT-1:2];

    // Memories also need the word index to fall inside their depth.
    assign ram_hit = (region == RAM_BASE[31:REGION_SHIFT]) && (word_ofs < RAM_WORDS);
    assign rom_hit = (region == ROM_BASE[31:REGION_SHIFT]) && (word_ofs < ROM_WORDS);
    assign led_hit = (region == LED_BASE[31:REGION_SHIFT]);
    assign i2c_hit = (region == I2C_BASE[31:REGION_SHIFT]);

    assign ram_sel  = mem_valid & ram_hit;
    assign rom_sel  = mem_valid & rom_hit;
    assign led_sel  = mem_valid & led_hit;
    assign i2c_sel  = mem_valid & i2c_hit;
    assign dflt_sel = mem_valid & ~(ram_hit | rom_hit | led_hit | i2c_hit);

    // Unmapped addresses get one ready with zero data.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dflt_ready <= 1'b0;
        end else begin
            dflt_ready <= dflt_sel & ~dflt_ready;
        end
    end

    // Idle targets keep rdata at zero, so OR is enough.
    assign mem_ready = ram_ready | rom_ready | led_ready | i2c_ready | dflt_ready;
    assign mem_rdata = ram_rdata | rom_rdata | led_rdata | i2c_rdata;

endmodule

//--- soc_i2c.sv
`timescale 1ns/1ns

module soc_i2c #(
    parameter int I2C_DIV = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  soc_pkg::addr_t addr,
    input  soc_pkg::data_t wdata,
    input  soc_pkg::strb_t wstrb,
    input  logic           sda_in,
    output logic           ready,
    output soc_pkg::data_t rdata,
    output logic           scl_low,
    output logic           sda_low
);

    import soc_pkg::*;

    localparam int DIV_W = (I2C_DIV > 1) ? $clog2(I2C_DIV) : 1;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_bit,
        st_ack,
        st_stop
    } i2c_state_t;

    i2c_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       quarter;
    logic [2:0]       bit_cnt;
    logic             data_phase;
    logic             busy;
    logic             nack;
    logic [7:0]       shift;
    logic [7:0]       data_byte;
    logic             accept;
    logic             ctrl_wr;
    logic             stat_rd;
    logic             start_xfer;
    logic             tick;
    logic             bit_done;
    logic             load_data;

    assign accept  = sel & ~ready;
    assign ctrl_wr = accept && (wstrb != '0)
                     && (addr[REGION_SHIFT-1:0] == I2C_CTRL_OFS[REGION_SHIFT-1:0]);
    assign stat_rd = accept && (wstrb == '0)
                     && (addr[REGION_SHIFT-1:0] == I2C_STAT_OFS[REGION_SHIFT-1:0]);

    // Commands during a transfer are acknowledged and dropped.
    assign start_xfer = ctrl_wr & ~busy;

    assign tick      = busy && (div_cnt == DIV_W'(I2C_DIV - 1));
    assign bit_done  = tick && (state == st_bit) && (quarter == 2'd3);
    assign load_data = tick && (state == st_ack) && (quarter == 2'd3) && !nack && !data_phase;

    // Address byte goes out with a zero write bit.
    always_ff @(posedge clk) begin
        if (start_xfer) begin
            shift     <= {wdata[6:0], 1'b0};
            data_byte <= wdata[15:8];
        end else if (bit_done) begin
            shift <= {shift[6:0], 1'b0};
        end else if (load_data) begin
            shift <= data_byte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready      <= 1'b0;
            rdata      <= '0;
            busy       <= 1'b0;
            nack       <= 1'b0;
            state      <= st_idle;
            div_cnt    <= '0;
            quarter    <= 2'd0;
            bit_cnt    <= 3'd0;
            data_phase <= 1'b0;
            scl_low    <= 1'b0;
            sda_low    <= 1'b0;
        end else begin
            ready <= accept;
            rdata <= stat_rd ? {30'd0, nack, busy} : '0;
            if (start_xfer) begin
                busy       <= 1'b1;
                nack       <= 1'b0;
                state      <= st_start;
                div_cnt    <= '0;
                quarter    <= 2'd0;
                bit_cnt    <= 3'd0;
                data_phase <= 1'b0;
            end else if (tick) begin
                div_cnt <= '0;
                quarter <= quarter + 2'd1;
                case (state)
                    // SDA falls while SCL is high.
                    st_start: begin
                        if (quarter == 2'd1) begin
                            sda_low <= 1'b1;
                        end
                        if (quarter == 2'd3) begin
                            scl_low <= 1'b1;
                            state   <= st_bit;
                        end
                    end
                    // Data changes with SCL low, MSB first.
                    st_bit: begin
                        case (quarter)
                            2'd0: sda_low <= ~shift[7];
                            2'd1: scl_low <= 1'b0;
                            2'd3: begin
                                scl_low <= 1'b1;
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7) begin
                                    state <= st_ack;
                                end
                            end
                            default: ;
                        endcase
                    end
                    st_ack: begin
                        case (quarter)
                            2'd0: sda_low <= 1'b0;
                            2'd1: scl_low <= 1'b0;
                            2'd2: begin
                                if (sda_in) begin
                                    nack <= 1'b1;
                                end
                            end
                            2'd3: begin
                                scl_low <= 1'b1;
                                if (nack || data_phase) begin
                                    state <= st_stop;
                                end else begin
                                    state      <= st_bit;
                                    data_phase <= 1'b1;
                                end
                            end
                        endcase
                    end
                    // SDA rises while SCL is high.
                    st_stop: begin
                        case (quarter)
                            2'd0: sda_low <= 1'b1;
                            2'd1: scl_low <= 1'b0;
                            2'd2: sda_low <= 1'b0;
                            2'd3: begin
                                busy  <= 1'b0;
                                state <= st_idle;
                            end
                        endcase
                    end
                    default: state <= st_idle;
                endcase
            end else if (busy) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- soc_led.sv
`timescale 1ns/1ns

module soc_led #(
    parameter int LED_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sel,
    input  soc_pkg::data_t       wdata,
    input  soc_pkg::strb_t       wstrb,
    output logic                 ready,
    output soc_pkg::data_t       rdata,
    output logic [LED_WIDTH-1:0] led
);

    import soc_pkg::*;

    logic accept;

    assign accept = sel & ~ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
            rdata <= '0;
            led   <= '0;
        end else begin
            ready <= accept;
            // Only the low byte lane holds LED bits.
            if (accept && wstrb[0]) begin
                led <= wdata[LED_WIDTH-1:0];
            end
            rdata <= (accept && wstrb == '0) ? data_t'(led) : '0;
        end
    end

endmodule

//--- soc_periph.sv
`timescale 1ns/1ns

module soc_periph #(
    parameter int RAM_WORDS = 1024,
    parameter int LED_WIDTH = 4,
    parameter int I2C_DIV   = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_valid,
    input  soc_pkg::addr_t       mem_addr,
    input  soc_pkg::data_t       mem_wdata,
    input  soc_pkg::strb_t       mem_wstrb,
    input  logic                 sda_in,
    output logic                 mem_ready,
    output soc_pkg::data_t       mem_rdata,
    output logic [LED_WIDTH-1:0] led,
    output logic                 scl_low,
    output logic                 sda_low
);

    import soc_pkg::*;

    logic  ram_sel;
    logic  rom_sel;
    logic  led_sel;
    logic  i2c_sel;
    logic  ram_ready;
    logic  rom_ready;
    logic  led_ready;
    logic  i2c_ready;
    data_t ram_rdata;
    data_t rom_rdata;
    data_t led_rdata;
    data_t i2c_rdata;

    soc_bus_ctrl #(
        .RAM_WORDS(RAM_WORDS)
    ) soc_bus_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .ram_ready (ram_ready),
        .rom_ready (rom_ready),
        .led_ready (led_ready),
        .i2c_ready (i2c_ready),
        .ram_rdata (ram_rdata),
        .rom_rdata (rom_rdata),
        .led_rdata (led_rdata),
        .i2c_rdata (i2c_rdata),
        .ram_sel   (ram_sel),
        .rom_sel   (rom_sel),
        .led_sel   (led_sel),
        .i2c_sel   (i2c_sel),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    soc_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) soc_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (ram_sel),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .ready (ram_ready),
        .rdata (ram_rdata)
    );

    soc_boot_rom soc_boot_rom_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (rom_sel),
        .addr  (mem_addr),
        .wstrb (mem_wstrb),
        .ready (rom_ready),
        .rdata (rom_rdata)
    );

    soc_led #(
        .LED_WIDTH(LED_WIDTH)
    ) soc_led_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (led_sel),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .ready (led_ready),
        .rdata (led_rdata),
        .led   (led)
    );

    soc_i2c #(
        .I2C_DIV(I2C_DIV)
    ) soc_i2c_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (i2c_sel),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .wstrb   (mem_wstrb),
        .sda_in  (sda_in),
        .ready   (i2c_ready),
        .rdata   (i2c_rdata),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

endmodule

//--- soc_pkg.sv
package soc_pkg;

    // Bus vector types.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // Address bits above this select the region.
    localparam int REGION_SHIFT = 24;

    // Region bases.
    localparam addr_t RAM_BASE = 32'h0000_0000;
    localparam addr_t ROM_BASE = 32'h0100_0000;
    localparam addr_t LED_BASE = 32'h0200_0000;
    localparam addr_t I2C_BASE = 32'h0300_0000;

    // Boot image size in words.
    localparam int ROM_WORDS = 16;

    // I2C register offsets inside its region.
    localparam addr_t I2C_CTRL_OFS = 32'h0000_0000;
    localparam addr_t I2C_STAT_OFS = 32'h0000_0004;

endpackage

//--- soc_ram.sv
`timescale 1ns/1ns

module soc_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  soc_pkg::addr_t addr,
    input  soc_pkg::data_t wdata,
    input  soc_pkg::strb_t wstrb,
    output logic           ready,
    output soc_pkg::data_t rdata
);

    import soc_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             accept;

    assign word_idx = addr[IDX_W+1:2];
    assign accept   = sel & ~ready;

    // Byte lanes are written only where the strobe is set.
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
            rdata <= '0;
        end else begin
            ready <= accept;
            // Read data shows only in the ready cycle.
            rdata <= (accept && wstrb == '0) ? mem[word_idx] : '0;
        end
    end

endmodule

//--- tb_i2c_target.sv
`timescale 1ns/1ns

module tb_i2c_target #(
    parameter logic [6:0] TARGET_ADDR = 7'h50
) (
    input  logic scl_low,
    input  logic sda_low,
    output logic sda_in
);

    logic       scl_line;
    logic       sda_line;
    logic       ack_drive  = 1'b0;
    logic       prev_scl   = 1'b1;
    logic       prev_sda   = 1'b1;
    logic       in_frame   = 1'b0;
    logic       byte_done  = 1'b0;
    logic       ack_slot   = 1'b0;
    logic       addressed  = 1'b0;
    logic       stop_seen  = 1'b0;
    logic [7:0] shreg      = 8'h00;
    logic [7:0] rx_bytes [4];
    int         bit_cnt    = 0;
    int         byte_count = 0;

    // Both lines are open drain with a pull-up.
    assign scl_line = ~scl_low;
    assign sda_line = ~(sda_low | ack_drive);
    assign sda_in   = sda_line;

    always @(scl_line or sda_line) begin
        if (scl_line && prev_scl && prev_sda && !sda_line) begin
            // START condition.
            in_frame   = 1'b1;
            byte_done  = 1'b0;
            ack_slot   = 1'b0;
            addressed  = 1'b0;
            stop_seen  = 1'b0;
            bit_cnt    = 0;
            byte_count = 0;
            for (int i = 0; i < 4; i++) begin
                rx_bytes[i] = 8'h00;
            end
        end else if (scl_line && prev_scl && !prev_sda && sda_line) begin
            // STOP condition.
            in_frame  = 1'b0;
            stop_seen = 1'b1;
        end else if (scl_line && !prev_scl) begin
            if (in_frame && !ack_slot) begin
                shreg = {shreg[6:0], sda_line};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    bit_cnt   = 0;
                    byte_done = 1'b1;
                    if (byte_count < 4) begin
                        rx_bytes[byte_count] = shreg;
                    end
                    if (byte_count == 0) begin
                        addressed = (shreg == {TARGET_ADDR, 1'b0});
                    end
                    byte_count++;
                end
            end
        end else if (!scl_line && prev_scl) begin
            // Hold SDA low for the whole acknowledge clock.
            if (byte_done) begin
                byte_done = 1'b0;
                ack_slot  = 1'b1;
                ack_drive = addressed;
            end else if (ack_slot) begin
                ack_slot  = 1'b0;
                ack_drive = 1'b0;
            end
        end
        prev_scl = scl_line;
        prev_sda = sda_line;
    end

endmodule

//--- tb_soc_periph.sv
`timescale 1ns/1ns

module tb_soc_periph;

    import soc_pkg::*;

    localparam int         RAM_WORDS  = 1024;
    localparam int         LED_WIDTH  = 4;
    localparam int         I2C_DIV    = 4;
    localparam logic [6:0] TGT_ADDR   = 7'h50;
    localparam logic [6:0] OTHER_ADDR = 7'h23;
    localparam int         RAM_SPAN   = 64;
    localparam int         RAM_WRITES = 200;
    localparam int         BUS_XFERS  = RAM_WRITES + RAM_SPAN + 40;
    localparam int         I2C_XFERS  = 3;
    localparam int         TIMEOUT_CYCLES = 2 * (10 * BUS_XFERS + 200 * I2C_DIV * I2C_XFERS);

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 mem_valid;
    addr_t                mem_addr;
    data_t                mem_wdata;
    strb_t                mem_wstrb;
    logic                 sda_in;
    logic                 mem_ready;
    data_t                mem_rdata;
    logic [LED_WIDTH-1:0] led;
    logic                 scl_low;
    logic                 sda_low;

    data_t                ram_model [RAM_SPAN];
    logic                 ram_written [RAM_SPAN];
    data_t                rom_image [ROM_WORDS];
    logic [LED_WIDTH-1:0] led_model;
    int                   seed;
    int                   pass_count   = 0;
    int                   fail_count   = 0;
    int                   fails_before = 0;

    soc_periph #(
        .RAM_WORDS(RAM_WORDS),
        .LED_WIDTH(LED_WIDTH),
        .I2C_DIV  (I2C_DIV)
    ) soc_periph_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .sda_in    (sda_in),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .led       (led),
        .scl_low   (scl_low),
        .sda_low   (sda_low)
    );

    tb_i2c_target #(
        .TARGET_ADDR(TGT_ADDR)
    ) i2c_tgt_i (
        .scl_low (scl_low),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

    always #5 clk = ~clk;

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [LED_WIDTH-1:0] next_led(logic [LED_WIDTH-1:0] old_led,
                                                       data_t wdata, strb_t strb);
        if (strb[0]) begin
            return wdata[LED_WIDTH-1:0];
        end
        return old_led;
    endfunction

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual === expected) pass_count++;
        else begin
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) pass_count++;
        else begin
            $display("%s", what);
            fail_count++;
        end
    endtask

    task automatic report_test(input string name);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) wrong", name, fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    // Performs one transfer and holds valid through the edge that samples ready.
    task automatic bus_xfer(input addr_t addr, input data_t wdata, input strb_t wstrb,
                            output data_t rdata);
        int wait_cycles;
        wait_cycles = 0;
        @(negedge clk);
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (mem_ready !== 1'b1);
        rdata = mem_rdata;
        @(negedge clk);
        // A second ready must not follow while valid is still high.
        check_value("mem_ready after transfer", '0, data_t'(mem_ready));
        check_value("mem_rdata after transfer", '0, mem_rdata);
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        check_value("mem_ready latency", 32'd1, data_t'(wait_cycles));
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
        data_t unused;
        bus_xfer(addr, wdata, wstrb, unused);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_xfer(addr, '0, '0, rdata);
    endtask

    task automatic test_reset();
        check_value("mem_ready", '0, data_t'(mem_ready));
        check_value("mem_rdata", '0, mem_rdata);
        check_value("led", '0, data_t'(led));
        check_value("scl_low", '0, data_t'(scl_low));
        check_value("sda_low", '0, data_t'(sda_low));
        report_test("reset");
    endtask

    task automatic test_ram();
        int    idx;
        data_t wdata;
        data_t rdata;
        strb_t strb;
        for (int i = 0; i < RAM_WRITES; i++) begin
            idx   = $unsigned($random(seed)) % RAM_SPAN;
            wdata = $random(seed);
            strb  = strb_t'($random(seed));
            if (strb == '0) begin
                strb = 4'h1;
            end
            // A fresh word gets all four bytes so no lane stays unknown.
            if (!ram_written[idx]) begin
                strb = 4'hf;
            end
            bus_write(RAM_BASE + addr_t'(idx * 4), wdata, strb);
            ram_model[idx]   = merge_bytes(ram_model[idx], wdata, strb);
            ram_written[idx] = 1'b1;
        end
        for (int i = 0; i < RAM_SPAN; i++) begin
            if (ram_written[i]) begin
                bus_read(RAM_BASE + addr_t'(i * 4), rdata);
                check_value($sformatf("mem_rdata ram[%0d]", i), ram_model[i], rdata);
            end
        end
        report_test("ram");
    endtask

    task automatic test_rom();
        data_t rdata;
        for (int i = 0; i < ROM_WORDS; i++) begin
            bus_read(ROM_BASE + addr_t'(i * 4), rdata);
            check_value($sformatf("mem_rdata rom[%0d]", i), rom_image[i], rdata);
        end
        bus_xfer(ROM_BASE + 32'h0c, 32'hffff_ffff, 4'hf, rdata);
        check_value("mem_rdata rom write", '0, rdata);
        bus_read(ROM_BASE + 32'h0c, rdata);
        check_value("mem_rdata rom[3] after write", rom_image[3], rdata);
        report_test("rom");
    endtask

    task automatic led_step(input data_t wdata, input strb_t strb);
        data_t rdata;
        bus_write(LED_BASE, wdata, strb);
        led_model = next_led(led_model, wdata, strb);
        check_value("led", data_t'(led_model), data_t'(led));
        bus_read(LED_BASE, rdata);
        check_value("mem_rdata led", data_t'(led_model), rdata);
    endtask

    task automatic test_led();
        led_step(32'h0000_005a, 4'h1);
        led_step(32'h0000_0003, 4'he);
        led_step(32'h0000_00f5, 4'hf);
        report_test("led");
    endtask

    // Sends one command and polls status until the transfer ends.
    task automatic i2c_send(input logic [6:0] tgt, input logic [7:0] value, input bit overlap,
                            output data_t status);
        bus_write(I2C_BASE + I2C_CTRL_OFS, {16'd0, value, 1'b0, tgt}, 4'hf);
        bus_read(I2C_BASE + I2C_STAT_OFS, status);
        check_value("i2c status busy", 32'd1, status & 32'd1);
        if (overlap) begin
            bus_write(I2C_BASE + I2C_CTRL_OFS, {16'd0, 8'hff, 1'b0, OTHER_ADDR}, 4'hf);
        end
        while (status[0]) begin
            bus_read(I2C_BASE + I2C_STAT_OFS, status);
        end
    endtask

    task automatic test_i2c();
        data_t status;
        i2c_send(TGT_ADDR, 8'ha5, 1'b0, status);
        check_value("i2c status nack", '0, data_t'(status[1]));
        check_value("i2c byte_count", 32'd2, data_t'(i2c_tgt_i.byte_count));
        check_value("i2c address byte", data_t'({TGT_ADDR, 1'b0}),
                    data_t'(i2c_tgt_i.rx_bytes[0]));
        check_value("i2c data byte", 32'h0000_00a5, data_t'(i2c_tgt_i.rx_bytes[1]));
        check_true("I2C target saw no STOP after the acknowledged transfer", i2c_tgt_i.stop_seen);
        i2c_send(OTHER_ADDR, 8'h3c, 1'b0, status);
        check_value("i2c status nack", 32'd1, data_t'(status[1]));
        check_value("i2c byte_count", 32'd1, data_t'(i2c_tgt_i.byte_count));
        check_true("I2C target saw no STOP after the refused transfer", i2c_tgt_i.stop_seen);
        i2c_send(TGT_ADDR, 8'h5a, 1'b1, status);
        check_value("i2c status nack", '0, data_t'(status[1]));
        check_value("i2c byte_count", 32'd2, data_t'(i2c_tgt_i.byte_count));
        check_value("i2c data byte", 32'h0000_005a, data_t'(i2c_tgt_i.rx_bytes[1]));
        report_test("i2c");
    endtask

    task automatic test_unmapped();
        data_t rdata;
        bus_write(RAM_BASE, 32'h1357_9bdf, 4'hf);
        ram_model[0] = 32'h1357_9bdf;
        bus_read(32'h0400_0000, rdata);
        check_value("mem_rdata region 0x04 read", '0, rdata);
        bus_xfer(32'h0400_0010, 32'hffff_ffff, 4'hf, rdata);
        check_value("mem_rdata region 0x04 write", '0, rdata);
        // Past the RAM end the low address bits alias word 0.
        bus_xfer(RAM_BASE + addr_t'(RAM_WORDS * 4), 32'h2468_ace0, 4'hf, rdata);
        check_value("mem_rdata ram end write", '0, rdata);
        bus_read(RAM_BASE + addr_t'(RAM_WORDS * 4), rdata);
        check_value("mem_rdata ram end read", '0, rdata);
        bus_read(ROM_BASE + addr_t'(ROM_WORDS * 4), rdata);
        check_value("mem_rdata rom end read", '0, rdata);
        bus_read(RAM_BASE, rdata);
        check_value("mem_rdata ram[0]", ram_model[0], rdata);
        bus_read(ROM_BASE, rdata);
        check_value("mem_rdata rom[0]", rom_image[0], rdata);
        report_test("unmapped");
    endtask

    initial begin
        seed      = 32'hec79_7ce9;
        rst_n     = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        led_model = '0;
        for (int i = 0; i < RAM_SPAN; i++) begin
            ram_model[i]   = '0;
            ram_written[i] = 1'b0;
        end
        $readmemh("boot_rom.hex", rom_image);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_ram();
        test_rom();
        test_led();
        test_i2c();
        test_unmapped();
        $display("checks passed: %0d, checks wrong: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule
